// File: heapPkg.sv
/*
  Heap package
  Sizes, vector types, command codes and error codes shared by the heap of arrays
*/
`default_nettype none

package heapPkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int arrayBits   = 3;                       // Bits in an array number
  localparam int indexBits   = 3;                       // Bits in an element index
  localparam int arrayLength = 1 << indexBits;          // Elements per array
  localparam int arrayCount  = 1 << arrayBits;          // Arrays in the heap
  localparam int dataBits    = 16;                      // Width of one element

  // --------------------
  // Vector types
  // --------------------
  typedef logic [arrayBits-1:0] arrayId;                // Number of an array
  typedef logic [indexBits-1:0] elementIndex;           // Position within an array
  typedef logic [indexBits:0]   arraySize;              // Element count, 0 to arrayLength
  typedef logic [dataBits-1:0]  dataWord;               // Value of one element

  // --------------------
  // Commands
  // --------------------
  typedef enum logic [3:0] {
    actAlloc    = 4'd0,                                 // Take a freed or fresh array
    actFree     = 4'd1,                                 // Give an array back
    actWrite    = 4'd2,                                 // Store in, may extend size
    actRead     = 4'd3,                                 // Fetch an element
    actSize     = 4'd4,                                 // Current element count
    actPush     = 4'd5,                                 // Append at the end
    actPop      = 4'd6,                                 // Remove from the end
    actAdd      = 4'd7,                                 // Element plus in
    actSubtract = 4'd8,                                 // Element minus in
    actOr       = 4'd9,                                 // Element or in
    actXor      = 4'd10,                                // Element xor in
    actAnd      = 4'd11                                 // Element and in
  } heapAction;

  // --------------------
  // Outcomes
  // --------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,                             // Command carried out
    errNotAllocated = 3'd1,                             // Array never taken or freed
    errOutOfBounds  = 3'd2,                             // Index not below size
    errFull         = 3'd3,                             // Push on a full array
    errEmpty        = 3'd4,                             // Pop on an empty array
    errOutOfMemory  = 3'd5                              // No array left to hand out
  } heapError;

endpackage

`default_nettype wire

// File: arrayDirectory.sv
/*
  Array directory
  Tracks which arrays are in use, their sizes, the stack of freed arrays and the
  high-water mark, and decides whether each command may go ahead
*/
`default_nettype none

module arrayDirectory import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        request,                          // One-cycle command strobe
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  output logic        grant,                            // Command passes all checks
  output elementIndex slot,                             // Element position for the store
  output dataWord     dirValue,                         // Size or chosen array
  output heapError    dirError
);

  logic [arrayCount-1:0] allocated;                     // One flag per array
  arraySize              sizes [arrayCount];            // Element count per array
  arrayId                freeStack [arrayCount];        // Freed arrays, last on top
  logic [arrayBits:0]    freeTop;                       // Entries on the free stack
  logic [arrayBits:0]    highWater;                     // Arrays ever handed out

  arraySize curSize;                                    // Size of the addressed array
  arrayId   chosen;                                     // Array an Alloc would take
  logic     canAlloc;                                   // Some array is available

  assign curSize = sizes[array];

  // --------------------
  // Alloc choice
  // --------------------
  always_comb begin
    canAlloc = 1'b1;
    if (freeTop != '0) begin
      chosen = freeStack[freeTop[arrayBits-1:0] - 1'b1]; // Most recently freed first
    end else begin
      chosen = highWater[arrayBits-1:0];                // Lowest never-used number
      if (highWater == arrayCount) begin
        canAlloc = 1'b0;                                // Nothing left
      end
    end
  end

  // --------------------
  // Checks and results
  // --------------------
  always_comb begin
    dirError = errNone;
    dirValue = '0;
    slot     = index;                                   // Default for Write, Read, updates
    if (action == actAlloc) begin
      dirValue = dataWord'(chosen);
      if (!canAlloc) begin
        dirError = errOutOfMemory;
      end
    end else if (!allocated[array]) begin
      dirError = errNotAllocated;                       // Covers double free as well
    end else begin
      case (action)
        actRead, actAdd, actSubtract, actOr, actXor, actAnd: begin
          if ({1'b0, index} >= curSize) begin
            dirError = errOutOfBounds;
          end
        end
        actSize: dirValue = dataWord'(curSize);
        actPush: begin
          slot = curSize[indexBits-1:0];                // Next free position
          if (curSize == arraySize'(arrayLength)) begin
            dirError = errFull;
          end
        end
        actPop: begin
          slot = elementIndex'(curSize - 1'b1);         // Last element
          if (curSize == '0) begin
            dirError = errEmpty;
          end
        end
        default: ;                                      // Free and Write need only allocation
      endcase
    end
  end

  assign grant = request && (dirError == errNone);

  // --------------------
  // State update
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated <= '0;                                  // Heap empty
      freeTop   <= '0;
      highWater <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (grant) begin
      case (action)
        actAlloc: begin
          allocated[chosen] <= 1'b1;
          sizes[chosen]     <= '0;                      // New array starts empty
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;                  // Pop the free stack
          end else begin
            highWater <= highWater + 1'b1;
          end
        end
        actFree: begin
          allocated[array]                    <= 1'b0;
          freeStack[freeTop[arrayBits-1:0]]   <= array;
          freeTop                             <= freeTop + 1'b1;
        end
        actWrite: begin
          if ({1'b0, index} >= curSize) begin
            sizes[array] <= arraySize'(index) + 1'b1;   // Grow to index+1
          end
        end
        actPush: sizes[array] <= curSize + 1'b1;
        actPop:  sizes[array] <= curSize - 1'b1;
        default: ;                                      // Read, Size, updates keep sizes
      endcase
    end
  end

  // --------------------
  // Assertions
  // --------------------
  freeStackBound: assert property (@(posedge clock) disable iff (reset)
    freeTop <= highWater && highWater <= arrayCount)
    else $error("Free stack larger than arrays ever used");

  // Only arrays below the high-water mark were ever handed out
  grantNeedsArray: assert property (@(posedge clock) disable iff (reset)
    grant && action != actAlloc |-> {1'b0, array} < highWater)
    else $error("Grant on an array never handed out");

endmodule

`default_nettype wire

// File: elementStore.sv
/*
  Element store
  Data words of every array, with the read and in-place update datapath
*/
`default_nettype none

module elementStore import heapPkg::*; (
  input  logic        clock,
  input  logic        grant,                            // Directory accepted the command
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex slot,                             // Position chosen by the directory
  input  dataWord     in,
  output dataWord     storeValue                        // Value a data command returns
);

  dataWord memory [arrayCount][arrayLength];            // All arrays in fixed blocks

  dataWord current;                                     // Addressed element
  dataWord newValue;                                    // Element after the command
  logic    writeEnable;

  assign current = memory[array][slot];

  // --------------------
  // Update datapath
  // --------------------
  always_comb begin
    case (action)
      actWrite, actPush: newValue = in;
      actAdd:            newValue = current + in;       // Wraps modulo 2^16
      actSubtract:       newValue = current - in;
      actOr:             newValue = current | in;
      actXor:            newValue = current ^ in;
      actAnd:            newValue = current & in;
      default:           newValue = current;            // Read and Pop return the element
    endcase
  end

  assign storeValue = newValue;

  always_comb begin
    case (action)
      actWrite, actPush, actAdd, actSubtract, actOr, actXor, actAnd:
        writeEnable = grant;
      default:
        writeEnable = 1'b0;                             // Pop only shrinks the size
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][slot] <= newValue;
    end
  end

  // --------------------
  // Assertions
  // --------------------
  // Without a grant the addressed word must come through the edge untouched
  holdWithoutGrant: assert property (@(posedge clock)
    !grant |=> memory[$past(array)][$past(slot)] === $past(current))
    else $error("Element changed without a grant");

endmodule

`default_nettype wire

// File: responseMerge.sv
/*
  Response merger
  Registers the result, error and completion pulse of each command
*/
`default_nettype none

module responseMerge import heapPkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      request,
  input  heapAction action,
  input  dataWord   dirValue,                           // From the directory
  input  heapError  dirError,
  input  dataWord   storeValue,                         // From the store
  output dataWord   out,
  output heapError  error,
  output logic      done                                // One cycle after each request
);

  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= errNone;
      done  <= 1'b0;
    end else begin
      done <= request;
      if (request) begin
        error <= dirError;
        if (dirError == errNone) begin                  // Failed commands keep out
          case (action)
            actSize, actAlloc:
              out <= dirValue;
            actWrite, actRead, actPop, actAdd, actSubtract, actOr, actXor, actAnd:
              out <= storeValue;
            default: ;                                  // Free and Push return nothing
          endcase
        end
      end
    end
  end

  // --------------------
  // Assertions
  // --------------------
  doneTracksRequest: assert property (@(posedge clock) disable iff (reset)
    done ##1 done |-> $past(request, 2) && $past(request))
    else $error("Done high twice without two requests");

endmodule

`default_nettype wire

// File: heapMemory.sv
/*
  Heap memory
  Top level of the array heap: directory, element store and response merger
*/
`default_nettype none

module heapMemory import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        request,                          // One command per strobe
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  input  dataWord     in,
  output dataWord     out,
  output heapError    error,
  output logic        done
);

  logic        grant;                                   // Directory to store
  elementIndex slot;
  dataWord     dirValue;                                // Results into the merger
  heapError    dirError;
  dataWord     storeValue;

  arrayDirectory u_arrayDirectory (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .action   (action),
    .array    (array),
    .index    (index),
    .grant    (grant),
    .slot     (slot),
    .dirValue (dirValue),
    .dirError (dirError)
  );

  elementStore u_elementStore (
    .clock      (clock),
    .grant      (grant),
    .action     (action),
    .array      (array),
    .slot       (slot),
    .in         (in),
    .storeValue (storeValue)
  );

  responseMerge u_responseMerge (
    .clock      (clock),
    .reset      (reset),
    .request    (request),
    .action     (action),
    .dirValue   (dirValue),
    .dirError   (dirError),
    .storeValue (storeValue),
    .out        (out),
    .error      (error),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: heapMemoryTb.sv
/*
  Heap memory testbench
  Drives commands through the array heap, predicts each result with a model
  and checks the DUT one cycle after every request
*/
`default_nettype none

module heapMemoryTb import heapPkg::*; ();

  localparam int driveDelay   = 5;                      // Inputs change after the edge
  localparam int resetCycles  = 3;
  localparam int idleCycles   = 3;                      // Gap after each test
  localparam int settleCycles = 2;                      // Last burst done reaches the count
  localparam int commandCount = 225 + 6 * idleCycles + settleCycles + resetCycles;
  localparam int watchdogTime = commandCount * 40 * 2;

  logic        clock;
  logic        reset;
  logic        request;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  dataWord     in;
  dataWord     out;
  heapError    error;
  logic        done;

  // --------------------
  // Model state
  // --------------------
  logic    allocM [arrayCount];                         // Array in use
  int      sizeM [arrayCount];
  arrayId  freeStackM [$];                              // Last freed at the back
  int      highWaterM;
  dataWord dataM [arrayCount][arrayLength];
  logic    knownM [arrayCount][arrayLength];            // Element ever written
  dataWord lastOut;                                     // What out holds
  logic    lastKnown;

  dataWord  expOut;                                     // Prediction for the driven command
  heapError expError;
  logic     expKnown;
  dataWord  expOutQ;                                    // Prediction being checked
  heapError expErrorQ;
  logic     expKnownQ;

  string testName;
  int    errorCount;
  int    errorsAtStart;
  int    testsRun;
  int    testsFailed;
  int    issuedCount;
  int    doneCount;

  heapMemory u_heapMemory (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .action  (action),
    .array   (array),
    .index   (index),
    .in      (in),
    .out     (out),
    .error   (error),
    .done    (done)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;                         // Period 40
  end

  initial begin
    #(watchdogTime);
    $display("Watchdog expired, the tests did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  always @(posedge clock) begin
    if (request) begin                                  // Hold prediction for the check
      expOutQ   <= expOut;
      expErrorQ <= expError;
      expKnownQ <= expKnown;
    end
    if (!reset && done) begin
      doneCount <= doneCount + 1;
    end
  end

  // --------------------
  // Checks
  // --------------------
  outMatches: assert property (@(posedge clock) disable iff (reset)
    request |=> (!expKnownQ || out == expOutQ))
    else begin
      errorCount++;
      $display("[ERROR] %s: out expected %h actual %h", testName, expOutQ, out);
    end

  errorMatches: assert property (@(posedge clock) disable iff (reset)
    request |=> error == expErrorQ)
    else begin
      errorCount++;
      $display("[ERROR] %s: error expected %s actual %s", testName,
               expErrorQ.name(), error.name());
    end

  doneAfterRequest: assert property (@(posedge clock) disable iff (reset)
    request |=> done)
    else begin
      errorCount++;
      $display("%s: done did not pulse after a request", testName);
    end

  doneOnlyAfterRequest: assert property (@(posedge clock) disable iff (reset)
    !request |=> !done)
    else begin
      errorCount++;
      $display("%s: done pulsed without a request", testName);
    end

  clearedByReset: assert property (@(posedge clock)
    $fell(reset) |-> !done && out == '0 && error == errNone)
    else begin
      errorCount++;
      $display("Outputs were not cleared by reset");
    end

  // --------------------
  // Model
  // --------------------
  task automatic modelCommand(input heapAction act, input arrayId arr,
                              input elementIndex idx, input dataWord value);
    heapError e;
    dataWord  o;
    logic     k;
    arrayId   pick;
    int       sz;
    int       ix;
    e  = errNone;
    o  = lastOut;                                       // Out holds unless a result comes
    k  = lastKnown;
    sz = sizeM[arr];
    ix = int'(idx);
    if (act == actAlloc) begin
      if (freeStackM.size() > 0) begin
        pick = freeStackM.pop_back();                   // Last freed comes back first
      end else if (highWaterM < arrayCount) begin
        pick = arrayId'(highWaterM);
        highWaterM++;
      end else begin
        e = errOutOfMemory;
      end
      if (e == errNone) begin
        allocM[pick] = 1'b1;
        sizeM[pick]  = 0;
        o = dataWord'(pick);
        k = 1'b1;
      end
    end else if (!allocM[arr]) begin
      e = errNotAllocated;
    end else begin
      case (act)
        actFree: begin
          allocM[arr] = 1'b0;
          freeStackM.push_back(arr);
        end
        actWrite: begin
          dataM[arr][ix]  = value;
          knownM[arr][ix] = 1'b1;
          if (ix >= sz) sizeM[arr] = ix + 1;            // Grow to index+1
          o = value;
          k = 1'b1;
        end
        actSize: begin
          o = dataWord'(sz);
          k = 1'b1;
        end
        actPush: begin
          if (sz == arrayLength) begin
            e = errFull;
          end else begin
            dataM[arr][sz]  = value;
            knownM[arr][sz] = 1'b1;
            sizeM[arr]      = sz + 1;
          end
        end
        actPop: begin
          if (sz == 0) begin
            e = errEmpty;
          end else begin
            o = dataM[arr][sz-1];
            k = knownM[arr][sz-1];
            sizeM[arr] = sz - 1;
          end
        end
        default: begin                                  // Read and the five updates
          if (ix >= sz) begin
            e = errOutOfBounds;
          end else begin
            case (act)
              actAdd:      dataM[arr][ix] = dataM[arr][ix] + value;
              actSubtract: dataM[arr][ix] = dataM[arr][ix] - value;
              actOr:       dataM[arr][ix] = dataM[arr][ix] | value;
              actXor:      dataM[arr][ix] = dataM[arr][ix] ^ value;
              actAnd:      dataM[arr][ix] = dataM[arr][ix] & value;
              default: ;                                // Read leaves the element
            endcase
            o = dataM[arr][ix];
            k = knownM[arr][ix];
          end
        end
      endcase
    end
    lastOut   = o;
    lastKnown = k;
    expOut    = o;
    expError  = e;
    expKnown  = k;
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic issueCommand(input heapAction act, input arrayId arr,
                              input elementIndex idx, input dataWord value);
    @(posedge clock);
    #driveDelay;
    request = 1'b1;
    action  = act;
    array   = arr;
    index   = idx;
    in      = value;
    issuedCount++;
    modelCommand(act, arr, idx, value);
  endtask

  task automatic waitIdle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #driveDelay;
      request = 1'b0;
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic closeTest();
    waitIdle(idleCycles);                               // Let the last check fire
    testsRun++;
    if (errorCount != errorsAtStart) begin
      testsFailed++;
      $display("test %s: failed, %0d errors", testName, errorCount - errorsAtStart);
    end else begin
      $display("test %s: ok", testName);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  initial begin
    arrayId      arr;
    elementIndex idx;
    int          issuedBase;
    int          doneBase;
    void'($urandom(95));
    reset = 1'b1;
    request = 1'b0;
    action = actAlloc;
    array = '0;
    index = '0;
    in = '0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    issuedCount = 0;
    doneCount = 0;
    highWaterM = 0;
    lastOut = '0;
    lastKnown = 1'b1;
    for (int a = 0; a < arrayCount; a++) begin
      allocM[a] = 1'b0;
      sizeM[a]  = 0;
      for (int i = 0; i < arrayLength; i++) begin
        dataM[a][i]  = '0;
        knownM[a][i] = 1'b0;
      end
    end
    repeat (resetCycles) @(posedge clock);
    #driveDelay;
    reset = 1'b0;

    startTest("allocAll");
    for (int i = 0; i <= arrayCount; i++) issueCommand(actAlloc, '0, '0, '0); // Ninth fails
    for (int i = 0; i < arrayCount; i++) issueCommand(actSize, arrayId'(i), '0, '0);
    closeTest();

    startTest("writeRead");
    for (int i = 0; i < 40; i++) begin
      issueCommand(actWrite, arrayId'($urandom % 6), elementIndex'($urandom),
                   dataWord'($urandom));
    end
    for (int i = 0; i < 40; i++) begin                  // Mix of hits and out of bounds
      issueCommand(actRead, arrayId'($urandom % 6), elementIndex'($urandom), '0);
    end
    closeTest();

    startTest("pushPop");
    for (int i = 0; i <= arrayLength; i++) issueCommand(actPush, 3'd6, '0, dataWord'($urandom));
    for (int i = 0; i <= arrayLength; i++) issueCommand(actPop, 3'd6, '0, '0);
    closeTest();

    startTest("updates");
    for (int i = 0; i < 30; i++) begin
      arr = arrayId'($urandom % 6);
      idx = (sizeM[arr] > 0) ? elementIndex'($urandom % sizeM[arr]) : '0;
      issueCommand(heapAction'(7 + $urandom % 5), arr, idx, dataWord'($urandom));
      issueCommand(actRead, arr, idx, '0);              // Stored value confirmed
    end
    closeTest();

    startTest("freeRealloc");
    issueCommand(actFree, 3'd2, '0, '0);
    issueCommand(actFree, 3'd3, '0, '0);
    issueCommand(actAlloc, '0, '0, '0);                 // Expect 3, then 2
    issueCommand(actAlloc, '0, '0, '0);
    issueCommand(actSize, 3'd3, '0, '0);
    issueCommand(actSize, 3'd2, '0, '0);
    issueCommand(actFree, 3'd4, '0, '0);
    issueCommand(actFree, 3'd4, '0, '0);                // Double free
    issueCommand(actRead, 3'd4, '0, '0);
    issueCommand(actWrite, 3'd4, '0, 16'h1234);
    closeTest();

    startTest("burst");
    issuedBase = issuedCount;
    doneBase   = doneCount;
    for (int i = 0; i < 40; i++) begin
      issueCommand(heapAction'($urandom % 12), arrayId'($urandom), elementIndex'($urandom),
                   dataWord'($urandom));
    end
    waitIdle(settleCycles);                             // Done of the last command counted
    doneTally: assert (doneCount - doneBase == issuedCount - issuedBase)
      else begin
        errorCount++;
        $display("[ERROR] %s: done pulses expected %0d actual %0d", testName,
                 issuedCount - issuedBase, doneCount - doneBase);
      end
    closeTest();

    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
heapPkg.sv
arrayDirectory.sv
elementStore.sv
responseMerge.sv
heapMemory.sv
heapMemoryTb.sv

// File: run.sh
#!/bin/sh
# Build and run the heap memory simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module heapMemoryTb \
  -f sources.f \
  -o heapSim

./obj_dir/heapSim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
else
  exit 1
fi
